/* hw/ch2_config.svh */
`ifndef CH2_CONFIG_SVH
`define CH2_CONFIG_SVH

// frequency value width, period is 2048 minus freq
`define CH2_FREQ_W 11

// full length count
`define CH2_LEN_MAX 64

// volume width
`define CH2_VOL_W 4

// envelope pace width
`define CH2_PACE_W 3

`endif

/* hw/ch2_pkg.sv */
`default_nettype none

`include "ch2_config.svh"

package ch2_pkg;

	// frequency value
	typedef logic [`CH2_FREQ_W-1:0] freq_t;

	// volume, 0 to 15
	typedef logic [`CH2_VOL_W-1:0] vol_t;

	// remaining length, 0 to full count
	typedef logic [$clog2(`CH2_LEN_MAX+1)-1:0] len_t;

	// envelope pace
	typedef logic [`CH2_PACE_W-1:0] pace_t;

	// duty selector
	typedef logic [1:0] duty_t;

	// position in the 8-step waveform
	typedef logic [2:0] step_t;

	// register index
	typedef logic [1:0] reg_sel_t;

endpackage

`default_nettype wire

/* hw/ch2_regs.sv */
`default_nettype none

`include "ch2_config.svh"

module ch2_regs import ch2_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wr,
	input  logic       rd,
	input  reg_sel_t   reg_sel,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	output duty_t      duty,
	output freq_t      freq,
	output vol_t       env_init,
	output logic       env_up,
	output pace_t      env_pace,
	output logic       dac_on,
	output logic       length_en,
	output logic       trigger,
	output logic       len_load,
	output logic [5:0] len_data
);

	logic [7:0] env_reg;
	logic [7:0] rd_mux;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			duty      <= '0;
			env_reg   <= '0;
			freq      <= '0;
			length_en <= 1'b0;
			trigger   <= 1'b0;
			len_load  <= 1'b0;
		end else begin
			trigger  <= 1'b0;
			len_load <= 1'b0;
			if (wr) begin
				case (reg_sel)
					2'd0: begin // duty / length
						duty     <= wdata[7:6];
						len_load <= 1'b1;
					end
					2'd1: env_reg <= wdata;
					2'd2: freq[7:0] <= wdata;
					2'd3: begin // freq high and control
						freq[`CH2_FREQ_W-1:8] <= wdata[`CH2_FREQ_W-9:0];
						length_en             <= wdata[6];
						trigger               <= wdata[7];
					end
					default: ;
				endcase
			end
		end
	end

	// length payload travels with len_load
	always_ff @(posedge clk) begin
		if (wr && reg_sel == 2'd0)
			len_data <= wdata[5:0];
	end

	assign env_init = env_reg[7:4];
	assign env_up   = env_reg[3];
	assign env_pace = env_reg[2:0];
	assign dac_on   = |env_reg[7:3]; // init volume or up bit set

	always_comb begin
		case (reg_sel)
			2'd0:    rd_mux = {duty, 6'h3f};
			2'd1:    rd_mux = env_reg;
			2'd2:    rd_mux = 8'hff; // write only
			default: rd_mux = {1'b1, length_en, 6'h3f};
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			rdata <= '0;
		else if (rd)
			rdata <= rd_mux; // held until next read
	end

endmodule

`default_nettype wire

/* hw/ch2_freq_timer.sv */
`default_nettype none

`include "ch2_config.svh"

module ch2_freq_timer import ch2_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  freq_t freq,
	input  logic  trigger,
	output logic  ftick
);

	// one bit wider than freq, a freq of 0 gives 2048
	logic [`CH2_FREQ_W:0] period;
	logic [`CH2_FREQ_W:0] cnt;

	assign period = {1'b1, {`CH2_FREQ_W{1'b0}}} - {1'b0, freq};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt   <= '0;
			ftick <= 1'b0;
		end else if (trigger) begin
			cnt   <= period; // restart the tone
			ftick <= 1'b0;
		end else if (cnt <= 1) begin
			cnt   <= period; // expiry, reload
			ftick <= 1'b1;
		end else begin
			cnt   <= cnt - 1'b1;
			ftick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/ch2_len_enable.sv */
`default_nettype none

`include "ch2_config.svh"

module ch2_len_enable import ch2_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       trigger,
	input  logic       dac_on,
	input  logic       len_load,
	input  logic [5:0] len_data,
	input  logic       length_en,
	input  logic       length_tick,
	output logic       ch_on
);

	len_t length;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			length <= '0;
			ch_on  <= 1'b0;
		end else if (trigger) begin
			ch_on <= dac_on;
			if (length == '0)
				length <= len_t'(`CH2_LEN_MAX); // full length on retrigger
		end else begin
			if (len_load) begin
				length <= len_t'(`CH2_LEN_MAX) - {1'b0, len_data};
			end else if (length_tick && length_en && length != '0) begin
				length <= length - 1'b1;
				if (length == len_t'(1))
					ch_on <= 1'b0; // length expired
			end
			if (!dac_on)
				ch_on <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hw/ch2_envelope.sv */
`default_nettype none

module ch2_envelope import ch2_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  trigger,
	input  vol_t  env_init,
	input  logic  env_up,
	input  pace_t env_pace,
	input  logic  env_tick,
	output vol_t  volume
);

	pace_t pace_cnt;
	logic  step_now;

	// last tick of a pace group
	assign step_now = env_tick && env_pace != '0 && pace_cnt <= pace_t'(1);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pace_cnt <= '0;
		end else if (trigger) begin
			pace_cnt <= env_pace;
		end else if (env_tick && env_pace != '0) begin
			if (step_now)
				pace_cnt <= env_pace; // reload
			else
				pace_cnt <= pace_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			volume <= '0;
		end else if (trigger) begin
			volume <= env_init;
		end else if (step_now) begin
			if (env_up && volume != '1)
				volume <= volume + 1'b1;
			else if (!env_up && volume != '0)
				volume <= volume - 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hw/ch2_wave_out.sv */
`default_nettype none

module ch2_wave_out import ch2_pkg::*; (
	input  logic  clk,
	input  logic  rst_n,
	input  logic  trigger,
	input  logic  ftick,
	input  duty_t duty,
	input  vol_t  volume,
	input  logic  ch_on,
	output vol_t  sample
);

	step_t      step;
	logic [7:0] pattern;
	logic       wave_bit;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			step <= '0;
		else if (trigger)
			step <= '0;
		else if (ftick)
			step <= step + 1'b1;
	end

	// step 0 is the leftmost bit
	always_comb begin
		case (duty)
			2'd0:    pattern = 8'b0000_0001; // 12.5%
			2'd1:    pattern = 8'b1000_0001; // 25%
			2'd2:    pattern = 8'b1000_0111; // 50%
			default: pattern = 8'b0111_1110; // 75%
		endcase
	end

	assign wave_bit = pattern[3'd7 - step];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sample <= '0;
		else
			sample <= (ch_on && wave_bit) ? volume : '0;
	end

endmodule

`default_nettype wire

/* hw/ch2_top.sv */
`default_nettype none

module ch2_top import ch2_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       wr,
	input  logic       rd,
	input  reg_sel_t   reg_sel,
	input  logic [7:0] wdata,
	input  logic       length_tick,
	input  logic       env_tick,
	output logic [7:0] rdata,
	output vol_t       sample,
	output logic       ch_on
);

	duty_t      duty;
	freq_t      freq;
	vol_t       env_init;
	logic       env_up;
	pace_t      env_pace;
	logic       dac_on;
	logic       length_en;
	logic       trigger;
	logic       len_load;
	logic [5:0] len_data;
	logic       ftick;
	vol_t       volume;

	ch2_regs u_ch2_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.wr        (wr),
		.rd        (rd),
		.reg_sel   (reg_sel),
		.wdata     (wdata),
		.rdata     (rdata),
		.duty      (duty),
		.freq      (freq),
		.env_init  (env_init),
		.env_up    (env_up),
		.env_pace  (env_pace),
		.dac_on    (dac_on),
		.length_en (length_en),
		.trigger   (trigger),
		.len_load  (len_load),
		.len_data  (len_data)
	);

	ch2_freq_timer u_ch2_freq_timer (
		.clk     (clk),
		.rst_n   (rst_n),
		.freq    (freq),
		.trigger (trigger),
		.ftick   (ftick)
	);

	ch2_len_enable u_ch2_len_enable (
		.clk         (clk),
		.rst_n       (rst_n),
		.trigger     (trigger),
		.dac_on      (dac_on),
		.len_load    (len_load),
		.len_data    (len_data),
		.length_en   (length_en),
		.length_tick (length_tick),
		.ch_on       (ch_on)
	);

	ch2_envelope u_ch2_envelope (
		.clk      (clk),
		.rst_n    (rst_n),
		.trigger  (trigger),
		.env_init (env_init),
		.env_up   (env_up),
		.env_pace (env_pace),
		.env_tick (env_tick),
		.volume   (volume)
	);

	ch2_wave_out u_ch2_wave_out (
		.clk     (clk),
		.rst_n   (rst_n),
		.trigger (trigger),
		.ftick   (ftick),
		.duty    (duty),
		.volume  (volume),
		.ch_on   (ch_on),
		.sample  (sample)
	);

endmodule

`default_nettype wire

/* sim/tb_clkgen.sv */
`default_nettype none

module tb_clkgen (
	output logic clk
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

endmodule

`default_nettype wire

/* sim/tb_ch2.sv */
`default_nettype none

module tb_ch2;
	timeunit 1ns;
	timeprecision 1ps;

	logic       clk;
	logic       rst_n;
	logic       wr;
	logic       rd;
	logic [1:0] reg_sel;
	logic [7:0] wdata;
	logic       length_tick;
	logic       env_tick;
	logic [7:0] rdata;
	logic [3:0] sample;
	logic       ch_on;

	int value_errors;
	int timeout_errors;

	logic [1:0] m_duty; // register image
	logic [7:0] m_env;
	logic       m_len_en;

	tb_clkgen u_tb_clkgen (.clk(clk));

	ch2_top u_ch2_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.wr          (wr),
		.rd          (rd),
		.reg_sel     (reg_sel),
		.wdata       (wdata),
		.length_tick (length_tick),
		.env_tick    (env_tick),
		.rdata       (rdata),
		.sample      (sample),
		.ch_on       (ch_on)
	);

	task automatic report_mismatch(input string name, input int expected, input int actual);
		value_errors++;
		$display("[ERROR] %0d ns %s expected %0d got %0d", $time, name, expected, actual);
	endtask

	function automatic logic [7:0] expected_readback(input logic [1:0] sel);
		case (sel)
			2'd0:    return {m_duty, 6'b111111};
			2'd1:    return m_env;
			2'd2:    return 8'hff;
			default: return {1'b1, m_len_en, 6'b111111};
		endcase
	endfunction

	function automatic logic [7:0] duty_pattern(input logic [1:0] d);
		case (d)
			2'd0:    return 8'b0000_0001;
			2'd1:    return 8'b1000_0001;
			2'd2:    return 8'b1000_0111;
			default: return 8'b0111_1110;
		endcase
	endfunction

	function automatic int ones_count(input logic [7:0] bits);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++)
			if (bits[i]) n++;
		return n;
	endfunction

	// all tasks start and end just after a falling edge
	task automatic idle(input int cycles);
		repeat (cycles) @(negedge clk);
	endtask

	task automatic reg_write(input logic [1:0] sel, input logic [7:0] data);
		wr      = 1'b1;
		reg_sel = sel;
		wdata   = data;
		@(negedge clk);
		wr = 1'b0;
		case (sel)
			2'd0:    m_duty = data[7:6];
			2'd1:    m_env = data;
			2'd3:    m_len_en = data[6];
			default: ;
		endcase
	endtask

	task automatic reg_read(input logic [1:0] sel, output logic [7:0] data);
		rd      = 1'b1;
		reg_sel = sel;
		@(negedge clk);
		rd   = 1'b0;
		data = rdata;
	endtask

	task automatic pulse_length_tick();
		length_tick = 1'b1;
		@(negedge clk);
		length_tick = 1'b0;
	endtask

	task automatic pulse_env_tick();
		env_tick = 1'b1;
		@(negedge clk);
		env_tick = 1'b0;
	endtask

	task automatic peak_sample(input int cycles, output int peak);
		peak = 0;
		repeat (cycles) begin
			@(negedge clk);
			if (int'(sample) > peak) peak = int'(sample);
		end
	endtask

	task automatic wait_ftick(input int limit);
		int  n;
		bit  seen;
		n    = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			@(negedge clk);
			n++;
			if (u_ch2_top.ftick) seen = 1'b1;
		end
		if (!seen) begin
			timeout_errors++;
			$display("timeout: no tone tick within %0d cycles", limit);
		end
	endtask

	initial begin
		logic [7:0]  rd_val;
		logic [1:0]  sel;
		logic [1:0]  duty;
		logic [10:0] freq;
		logic [5:0]  len;
		logic [3:0]  init;
		logic        up;
		logic [2:0]  pace;
		int          period;
		int          cnt;
		int          peak;
		int          vol;
		int          n_ticks;

		rst_n          = 1'b0;
		wr             = 1'b0;
		rd             = 1'b0;
		reg_sel        = 2'd0;
		wdata          = 8'h00;
		length_tick    = 1'b0;
		env_tick       = 1'b0;
		value_errors   = 0;
		timeout_errors = 0;
		m_duty         = 2'd0;
		m_env          = 8'h00;
		m_len_en       = 1'b0;
		void'($urandom(32'h3b4d));
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		if (rdata !== 8'h00) report_mismatch("rdata", 0, int'(rdata));
		if (sample !== 4'h0) report_mismatch("sample", 0, int'(sample));
		if (ch_on !== 1'b0) report_mismatch("ch_on", 0, int'(ch_on));

		for (int i = 0; i < 200; i++) begin
			sel = 2'($urandom_range(3, 0));
			reg_write(sel, 8'($urandom));
			sel = 2'($urandom_range(3, 0));
			reg_read(sel, rd_val);
			if (rd_val !== expected_readback(sel))
				report_mismatch("rdata", int'(expected_readback(sel)), int'(rd_val));
		end

		for (int t = 0; t < 4; t++) begin
			duty   = 2'($urandom_range(3, 0));
			freq   = 11'($urandom_range(2047, 1536));
			period = 2048 - int'(freq);
			reg_write(2'd1, 8'hf0); // volume 15, pace 0
			reg_write(2'd0, {duty, 6'($urandom)});
			reg_write(2'd2, freq[7:0]);
			reg_write(2'd3, {5'b10000, freq[10:8]}); // trigger, length off
			idle(1);
			wait_ftick(period + 4);
			cnt = 0;
			repeat (8 * period) begin
				@(negedge clk);
				if (sample != 4'd0) cnt++;
			end
			if (cnt != ones_count(duty_pattern(duty)) * period)
				report_mismatch("sample high cycles", ones_count(duty_pattern(duty)) * period, cnt);
		end

		for (int t = 0; t < 3; t++) begin
			len     = 6'($urandom);
			n_ticks = 64 - int'(len);
			reg_write(2'd1, 8'hf0);
			reg_write(2'd0, {2'b10, len});
			reg_write(2'd3, 8'hc7); // trigger with length enabled
			idle(1);
			if (ch_on !== 1'b1) report_mismatch("ch_on", 1, int'(ch_on));
			for (int k = 1; k <= n_ticks; k++) begin
				pulse_length_tick();
				if (k < n_ticks && ch_on !== 1'b1) report_mismatch("ch_on", 1, int'(ch_on));
				if (k == n_ticks && ch_on !== 1'b0) report_mismatch("ch_on", 0, int'(ch_on));
			end
		end

		reg_write(2'd0, 8'hc0); // six high steps of eight
		reg_write(2'd2, 8'hff); // one clock per step with 8'h87 below
		for (int t = 0; t < 4; t++) begin
			init = 4'($urandom);
			up   = 1'($urandom);
			pace = 3'($urandom_range(7, 1));
			reg_write(2'd1, {init, up, pace});
			reg_write(2'd3, 8'h87);
			idle(1);
			vol = int'(init);
			peak_sample(16, peak);
			if (peak != vol) report_mismatch("sample peak", vol, peak);
			for (int g = 0; g < 16; g++) begin
				repeat (pace) pulse_env_tick();
				if (up && vol < 15)
					vol++;
				else if (!up && vol > 0)
					vol--;
				peak_sample(16, peak);
				if (peak != vol) report_mismatch("sample peak", vol, peak);
			end
		end

		init = 4'($urandom_range(15, 1));
		reg_write(2'd1, {init, 1'($urandom), 3'd0}); // frozen volume
		reg_write(2'd3, 8'h87);
		idle(1);
		repeat (10) pulse_env_tick();
		peak_sample(16, peak);
		if (peak != int'(init)) report_mismatch("sample peak", int'(init), peak);

		reg_write(2'd1, {5'b00000, 3'($urandom)}); // dac off
		reg_write(2'd3, 8'h87);
		idle(1);
		if (ch_on !== 1'b0) report_mismatch("ch_on", 0, int'(ch_on));
		peak_sample(16, peak);
		if (peak != 0) report_mismatch("sample peak", 0, peak);
		reg_write(2'd1, 8'hf0);
		reg_write(2'd3, 8'h87);
		idle(1);
		if (ch_on !== 1'b1) report_mismatch("ch_on", 1, int'(ch_on));
		reg_write(2'd1, 8'h07);
		if (ch_on !== 1'b1) report_mismatch("ch_on", 1, int'(ch_on));
		idle(1);
		if (ch_on !== 1'b0) report_mismatch("ch_on", 0, int'(ch_on));
		peak_sample(16, peak);
		if (peak != 0) report_mismatch("sample peak", 0, peak);

		$display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* compile.f */
+incdir+hw
hw/ch2_pkg.sv
hw/ch2_regs.sv
hw/ch2_freq_timer.sv
hw/ch2_len_enable.sv
hw/ch2_envelope.sv
hw/ch2_wave_out.sv
hw/ch2_top.sv
sim/tb_clkgen.sv
sim/tb_ch2.sv

/* Makefile */
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timescale 1ns/1ps --top-module tb_ch2 -f compile.f -o Vtb_ch2

run: build
	./obj_dir/Vtb_ch2 | tee run.log
	grep -q -F "*** TEST PASSED ***" run.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps --top-module ch2_top -f compile.f

clean:
	rm -rf obj_dir run.log
